// ==== hw/i2c_ctrl_pkg.sv ====
package i2c_ctrl_pkg;

    // --------------------
    // widths and slot counts
    localparam int PRESCALE_W   = 8;
    localparam int MIN_PRESCALE = 2;
    localparam int PHASE_W      = PRESCALE_W + 1;    // holds 2*P - 1
    localparam int SLOT_W       = 4;
    localparam int BYTE_SLOTS   = 8;                 // addr and data bytes
    localparam int ACK_SLOTS    = 1;                 // ack, start, stop, rstart

    // --------------------
    // sequencer states
    typedef enum logic [3:0] {
        IDLE       = 4'd0,
        START      = 4'd1,
        ADDR       = 4'd2,
        ADDR_ACK   = 4'd3,
        WRITE_DATA = 4'd4,
        DATA_ACK   = 4'd5,
        READ_DATA  = 4'd6,
        MASTER_ACK = 4'd7,
        RSTART     = 4'd8,
        STOP       = 4'd9
    } seq_state_e;

    // --------------------
    // grouped signals
    typedef struct packed {
        logic enable;
        logic rw;              // 1 = read
        logic repeat_start;
    } i2c_cmd_t;

    typedef struct packed {
        logic trans_empty;
        logic rev_full;
    } fifo_status_t;

    typedef struct packed {
        logic hold_done;       // start hold countdown finished
        logic slot_end;        // last core cycle of a bit slot
        logic phase_done;      // last slot of the current state
        logic sda_ack;         // sda sampled at mid slot
    } slot_evt_t;

    typedef struct packed {
        logic start_cnt;
        logic write_addr_cnt;
        logic write_data_cnt;
        logic read_data_cnt;
        logic write_ack_cnt;
        logic read_ack_cnt;
        logic stop_cnt;
        logic repeat_start_cnt;
    } phase_strobe_t;

    // number of bit slots spent in a state
    function automatic logic [SLOT_W-1:0] state_slots(input seq_state_e state);
        if (state == ADDR || state == WRITE_DATA || state == READ_DATA)
            return SLOT_W'(BYTE_SLOTS);
        return SLOT_W'(ACK_SLOTS);
    endfunction

endpackage

// ==== hw/i2c_bit_timer.sv ====
module i2c_bit_timer (
    input  logic                                i2c_core_clock_i,
    input  logic                                reset_bit_i,
    input  i2c_ctrl_pkg::seq_state_e            state_i,
    input  logic                                enable_i,
    input  logic                                sda_i,
    input  logic [i2c_ctrl_pkg::PRESCALE_W-1:0] prescaler_i,
    input  logic [i2c_ctrl_pkg::PRESCALE_W-1:0] hold_time_i,
    output i2c_ctrl_pkg::slot_evt_t             evt_o
);
    import i2c_ctrl_pkg::*;

    seq_state_e            prev_state_q;
    logic                  state_chg;
    logic [PHASE_W-1:0]    phase_q;
    logic [PHASE_W-1:0]    phase_cur;
    logic [PHASE_W-1:0]    phase_last;
    logic [SLOT_W-1:0]     slot_q;
    logic [SLOT_W-1:0]     slot_cur;
    logic [SLOT_W-1:0]     slot_last;
    logic                  slot_end;
    logic                  sda_ack_q;
    logic [PRESCALE_W-1:0] hold_cnt_q;
    logic                  hold_busy_q;

    // --------------------
    // slot and phase counting
    assign state_chg  = (state_i != prev_state_q);        // first cycle of a new state
    assign phase_cur  = state_chg ? '0 : phase_q;
    assign slot_cur   = state_chg ? '0 : slot_q;
    assign phase_last = {prescaler_i, 1'b0} - PHASE_W'(1); // slot is 2*P cycles
    assign slot_last  = state_slots(state_i) - SLOT_W'(1);
    assign slot_end   = (state_i != IDLE) && (phase_cur == phase_last);

    always_ff @(posedge i2c_core_clock_i or negedge reset_bit_i) begin
        if (!reset_bit_i) begin
            prev_state_q <= IDLE;
            phase_q      <= '0;
            slot_q       <= '0;
        end else begin
            prev_state_q <= state_i;
            if (state_i == IDLE) begin
                phase_q <= '0;
                slot_q  <= '0;
            end else if (slot_end) begin
                phase_q <= '0;
                slot_q  <= slot_cur + 1'b1;
            end else begin
                phase_q <= phase_cur + 1'b1;
                slot_q  <= slot_cur;
            end
        end
    end

    // sample sda in the middle of each slot
    always_ff @(posedge i2c_core_clock_i or negedge reset_bit_i) begin
        if (!reset_bit_i)
            sda_ack_q <= 1'b0;
        else if (state_i != IDLE && phase_cur == {1'b0, prescaler_i})
            sda_ack_q <= sda_i;
    end

    // --------------------
    // start hold countdown
    always_ff @(posedge i2c_core_clock_i or negedge reset_bit_i) begin
        if (!reset_bit_i) begin
            hold_busy_q <= 1'b0;
            hold_cnt_q  <= '0;
        end else if (state_i != IDLE || !enable_i) begin
            hold_busy_q <= 1'b0;                          // rearmed on next idle enable
        end else if (!hold_busy_q) begin
            hold_busy_q <= 1'b1;
            hold_cnt_q  <= hold_time_i;
        end else if (hold_cnt_q != '0) begin
            hold_cnt_q  <= hold_cnt_q - 1'b1;
        end
    end

    assign evt_o.hold_done  = hold_busy_q && (hold_cnt_q == '0) && (state_i == IDLE);
    assign evt_o.slot_end   = slot_end;
    assign evt_o.phase_done = slot_end && (slot_cur == slot_last);
    assign evt_o.sda_ack    = sda_ack_q;

    // --------------------
    // checks
    prescale_min_a : assert property (
        @(posedge i2c_core_clock_i) disable iff (!reset_bit_i)
        (state_i != IDLE) |-> (prescaler_i >= PRESCALE_W'(MIN_PRESCALE))
    ) else $error("prescaler below minimum while bus active");

    slot_range_a : assert property (
        @(posedge i2c_core_clock_i) disable iff (!reset_bit_i)
        slot_q <= SLOT_W'(BYTE_SLOTS)
    ) else $error("slot count past a full byte");

endmodule

// ==== hw/i2c_seq_decode.sv ====
module i2c_seq_decode (
    input  logic                         i2c_core_clock_i,
    input  logic                         reset_bit_i,
    input  i2c_ctrl_pkg::i2c_cmd_t       cmd_i,
    input  i2c_ctrl_pkg::fifo_status_t   fifo_status_i,
    input  i2c_ctrl_pkg::slot_evt_t      evt_i,
    output i2c_ctrl_pkg::seq_state_e     state_o
);
    import i2c_ctrl_pkg::*;

    seq_state_e state_q;
    seq_state_e state_d;
    seq_state_e end_state;   // where a finished transfer goes

    assign end_state = cmd_i.repeat_start ? RSTART : STOP;

    // --------------------
    // next state
    always_comb begin
        state_d = state_q;
        if (state_q == IDLE) begin
            if (cmd_i.enable && evt_i.hold_done)
                state_d = START;
        end else if (evt_i.phase_done) begin
            case (state_q)
                START: begin
                    state_d = ADDR;
                end
                ADDR: begin
                    state_d = ADDR_ACK;
                end
                ADDR_ACK: begin
                    if (evt_i.sda_ack)                     // slave nacked address
                        state_d = end_state;
                    else if (cmd_i.rw)
                        state_d = READ_DATA;
                    else
                        state_d = WRITE_DATA;
                end
                WRITE_DATA: begin
                    state_d = DATA_ACK;
                end
                DATA_ACK: begin
                    if (evt_i.sda_ack || fifo_status_i.trans_empty)
                        state_d = end_state;
                    else
                        state_d = WRITE_DATA;
                end
                READ_DATA: begin
                    state_d = MASTER_ACK;
                end
                MASTER_ACK: begin
                    if (fifo_status_i.rev_full)            // no room for another byte
                        state_d = end_state;
                    else
                        state_d = READ_DATA;
                end
                RSTART: begin
                    state_d = ADDR;
                end
                STOP: begin
                    state_d = IDLE;
                end
                default: begin
                    state_d = IDLE;
                end
            endcase
        end
    end

    // --------------------
    // state register
    always_ff @(posedge i2c_core_clock_i or negedge reset_bit_i) begin
        if (!reset_bit_i)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

    assign state_o = state_q;

    // start condition always hands over to the address byte
    start_to_addr_a : assert property (
        @(posedge i2c_core_clock_i) disable iff (!reset_bit_i)
        (state_q == START) |=> (state_q inside {START, ADDR})
    ) else $error("sequencer left START for %s", state_q.name());

endmodule

// ==== hw/i2c_line_ctrl.sv ====
module i2c_line_ctrl (
    input  logic                          i2c_core_clock_i,
    input  logic                          reset_bit_i,
    input  i2c_ctrl_pkg::seq_state_e      state_i,
    output i2c_ctrl_pkg::phase_strobe_t   strobe_o,
    output logic                          scl_en_o,
    output logic                          sda_en_o
);
    import i2c_ctrl_pkg::*;

    phase_strobe_t strobe_d;
    logic          scl_en_d;
    logic          sda_en_d;

    // --------------------
    // per state decode
    always_comb begin
        strobe_d = '0;
        scl_en_d = 1'b0;
        sda_en_d = 1'b0;
        case (state_i)
            START: begin
                strobe_d.start_cnt = 1'b1;
                sda_en_d           = 1'b1;       // scl left to the clock generator
            end
            ADDR: begin
                strobe_d.write_addr_cnt = 1'b1;
                scl_en_d                = 1'b1;
                sda_en_d                = 1'b1;
            end
            ADDR_ACK, DATA_ACK: begin
                strobe_d.read_ack_cnt = 1'b1;    // slave owns sda
                scl_en_d              = 1'b1;
            end
            WRITE_DATA: begin
                strobe_d.write_data_cnt = 1'b1;
                scl_en_d                = 1'b1;
                sda_en_d                = 1'b1;
            end
            READ_DATA: begin
                strobe_d.read_data_cnt = 1'b1;
                scl_en_d               = 1'b1;
            end
            MASTER_ACK: begin
                strobe_d.write_ack_cnt = 1'b1;
                scl_en_d               = 1'b1;
                sda_en_d               = 1'b1;
            end
            RSTART: begin
                strobe_d.repeat_start_cnt = 1'b1;
                scl_en_d                  = 1'b1;
                sda_en_d                  = 1'b1;
            end
            STOP: begin
                strobe_d.stop_cnt = 1'b1;
                sda_en_d          = 1'b1;
            end
            default: begin
                strobe_d = '0;                   // idle keeps the bus released
            end
        endcase
    end

    // --------------------
    // output registers, one cycle behind the state
    always_ff @(posedge i2c_core_clock_i or negedge reset_bit_i) begin
        if (!reset_bit_i) begin
            strobe_o <= '0;
            scl_en_o <= 1'b0;
            sda_en_o <= 1'b0;
        end else begin
            strobe_o <= strobe_d;
            scl_en_o <= scl_en_d;
            sda_en_o <= sda_en_d;
        end
    end

    strobe_onehot_a : assert property (
        @(posedge i2c_core_clock_i) disable iff (!reset_bit_i)
        $onehot0(strobe_o)
    ) else $error("more than one phase strobe active");

endmodule

// ==== hw/i2c_master_ctrl.sv ====
module i2c_master_ctrl (
    input  logic                                i2c_core_clock_i,
    input  logic                                reset_bit_i,
    input  i2c_ctrl_pkg::i2c_cmd_t              cmd_i,
    input  i2c_ctrl_pkg::fifo_status_t          fifo_status_i,
    input  logic                                sda_i,
    input  logic [i2c_ctrl_pkg::PRESCALE_W-1:0] prescaler_i,
    input  logic [i2c_ctrl_pkg::PRESCALE_W-1:0] hold_time_i,
    output i2c_ctrl_pkg::phase_strobe_t         strobe_o,
    output logic                                scl_en_o,
    output logic                                sda_en_o
);
    import i2c_ctrl_pkg::*;

    seq_state_e state;      // decode to timer and line control
    slot_evt_t  slot_evt;   // timer to decode

    // --------------------
    // execute stage
    i2c_bit_timer u_bit_timer (
        .i2c_core_clock_i (i2c_core_clock_i),
        .reset_bit_i      (reset_bit_i),
        .state_i          (state),
        .enable_i         (cmd_i.enable),
        .sda_i            (sda_i),
        .prescaler_i      (prescaler_i),
        .hold_time_i      (hold_time_i),
        .evt_o            (slot_evt)
    );

    // --------------------
    // decode stage
    i2c_seq_decode u_seq_decode (
        .i2c_core_clock_i (i2c_core_clock_i),
        .reset_bit_i      (reset_bit_i),
        .cmd_i            (cmd_i),
        .fifo_status_i    (fifo_status_i),
        .evt_i            (slot_evt),
        .state_o          (state)
    );

    // --------------------
    // result stage
    i2c_line_ctrl u_line_ctrl (
        .i2c_core_clock_i (i2c_core_clock_i),
        .reset_bit_i      (reset_bit_i),
        .state_i          (state),
        .strobe_o         (strobe_o),
        .scl_en_o         (scl_en_o),
        .sda_en_o         (sda_en_o)
    );

endmodule

// ==== dv/i2c_ctrl_checker.sv ====
module i2c_ctrl_checker (
    input  logic                        i2c_core_clock_i,
    input  logic                        reset_bit_i,
    input  i2c_ctrl_pkg::phase_strobe_t strobe_i,
    input  logic                        scl_en_i,
    input  logic                        sda_en_i,
    input  logic                        txn_start_i,
    input  logic                        txn_end_i,
    input  logic                        rw_i,
    input  logic                        rs_i,
    input  logic [15:0]                 acks_i,
    input  int                          nbytes_i,
    input  int                          presc_i,
    input  int                          hold_i,
    input  int                          txn_id_i,
    output int                          value_errs_o,
    output int                          timing_errs_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import i2c_ctrl_pkg::*;

    phase_strobe_t exp_strobe [64];
    int            exp_len [64];
    int            exp_cnt = 0;
    int            idx = 0;
    int            cyc = 0;
    int            en_cyc = 0;
    int            len = 0;
    int            run_id = 0;
    logic          wait_start = 1'b0;
    logic [1:0]    exp_en = 2'b00;
    phase_strobe_t cur = '0;

    initial begin
        value_errs_o  = 0;
        timing_errs_o = 0;
    end

    function automatic phase_strobe_t strobe_of(input seq_state_e s);
        phase_strobe_t st;
        st = '0;
        case (s)
            START:              st.start_cnt        = 1'b1;
            ADDR:               st.write_addr_cnt   = 1'b1;
            ADDR_ACK, DATA_ACK: st.read_ack_cnt     = 1'b1;
            WRITE_DATA:         st.write_data_cnt   = 1'b1;
            READ_DATA:          st.read_data_cnt    = 1'b1;
            MASTER_ACK:         st.write_ack_cnt    = 1'b1;
            RSTART:             st.repeat_start_cnt = 1'b1;
            STOP:               st.stop_cnt         = 1'b1;
            default:            st = '0;
        endcase
        return st;
    endfunction

    // {scl_en, sda_en} expected for the phase a strobe stands for
    function automatic logic [1:0] en_of(input phase_strobe_t st);
        logic scl;
        logic sda;
        scl = st.write_addr_cnt | st.read_ack_cnt | st.write_data_cnt | st.read_data_cnt
            | st.write_ack_cnt | st.repeat_start_cnt;
        sda = st.start_cnt | st.write_addr_cnt | st.write_data_cnt | st.write_ack_cnt
            | st.repeat_start_cnt | st.stop_cnt;
        return {scl, sda};
    endfunction

    // --------------------
    // reference sequence built by walking the transition rules
    function automatic int build_phases(input logic rw, input logic rs, input logic [15:0] acks,
                                        input int nbytes, input int p);
        seq_state_e s;
        int         n;
        int         bytes;
        logic [3:0] ai;
        logic       rs_l;
        s     = START;
        n     = 0;
        bytes = 0;
        ai    = 4'd0;
        rs_l  = rs;
        while (s != IDLE && n < 64) begin
            exp_strobe[n] = strobe_of(s);
            exp_len[n]    = (s == ADDR || s == WRITE_DATA || s == READ_DATA) ? 16 * p : 2 * p;
            n++;
            case (s)
                START:      s = ADDR;
                ADDR:       s = ADDR_ACK;
                ADDR_ACK: begin
                    if (acks[ai])
                        s = rs_l ? RSTART : STOP;   // address nack
                    else
                        s = rw ? READ_DATA : WRITE_DATA;
                    ai = ai + 4'd1;
                end
                WRITE_DATA: begin
                    bytes++;
                    s = DATA_ACK;
                end
                DATA_ACK: begin
                    if (acks[ai] || bytes >= nbytes)
                        s = rs_l ? RSTART : STOP;
                    else
                        s = WRITE_DATA;
                    ai = ai + 4'd1;
                end
                READ_DATA: begin
                    bytes++;
                    s = MASTER_ACK;
                end
                MASTER_ACK: s = (bytes >= nbytes) ? (rs_l ? RSTART : STOP) : READ_DATA;
                RSTART: begin
                    rs_l = 1'b0;                    // stimulus clears repeat start here
                    s    = ADDR;
                end
                default:    s = IDLE;
            endcase
        end
        return n;
    endfunction

    // --------------------
    // compare process samples on the falling edge where outputs are stable
    always @(negedge i2c_core_clock_i) begin
        if (!reset_bit_i) begin
            if (strobe_i != '0 || scl_en_i || sda_en_i) begin
                $display("outputs not cleared while reset is held");
                value_errs_o++;
            end
        end else begin
            cyc++;
            if (txn_start_i) begin
                if (idx != exp_cnt) begin
                    $display("txn%0d ended with %0d phases missing", run_id, exp_cnt - idx);
                    timing_errs_o++;
                end
                exp_cnt    = build_phases(rw_i, rs_i, acks_i, nbytes_i, presc_i);
                idx        = 0;
                en_cyc     = cyc;
                run_id     = txn_id_i;
                wait_start = 1'b1;
            end
            if (txn_end_i && idx != exp_cnt) begin
                $display("txn%0d ended with %0d phases missing", run_id, exp_cnt - idx);
                timing_errs_o++;
                idx = exp_cnt;
            end
            if (strobe_i != cur) begin
                if (cur != '0) begin
                    if (idx >= exp_cnt) begin
                        $display("[FAIL] txn%0d extra phase: expected 00 actual %02h",
                                 txn_id_i, cur);
                        value_errs_o++;
                    end else if (cur != exp_strobe[idx]) begin
                        $display("[FAIL] txn%0d phase%0d strobe: expected %02h actual %02h",
                                 txn_id_i, idx, exp_strobe[idx], cur);
                        value_errs_o++;
                    end else if (len != exp_len[idx]) begin
                        $display("[FAIL] txn%0d phase%0d length: expected %0d actual %0d",
                                 txn_id_i, idx, exp_len[idx], len);
                        timing_errs_o++;
                    end
                    idx++;
                end
                // enable is seen by the DUT one edge after it shows here
                if (strobe_i.start_cnt && wait_start) begin
                    wait_start = 1'b0;
                    if (cyc - en_cyc != hold_i + 3) begin
                        $display("[FAIL] txn%0d start latency: expected %0d actual %0d",
                                 txn_id_i, hold_i + 3, cyc - en_cyc);
                        timing_errs_o++;
                    end
                end
                cur = strobe_i;
                len = 1;
            end else begin
                len++;
            end
            // line enables follow the expected phase, released between phases
            exp_en = (cur != '0 && idx < exp_cnt) ? en_of(exp_strobe[idx]) : 2'b00;
            if ({scl_en_i, sda_en_i} != exp_en) begin
                $display("[FAIL] txn%0d line enables: expected %02b actual %02b",
                         txn_id_i, exp_en, {scl_en_i, sda_en_i});
                value_errs_o++;
            end
        end
    end

endmodule

// ==== dv/i2c_ctrl_tb.sv ====
module i2c_ctrl_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import i2c_ctrl_pkg::*;

    localparam int     NTXN        = 8;
    localparam longint WATCHDOG_NS = NTXN * (7 + 80 * 2 * 6) * 20 + 5000;

    logic          clk       = 1'b0;
    logic          reset_bit = 1'b0;
    i2c_cmd_t      cmd       = '0;
    fifo_status_t  fifo      = '0;
    logic          sda       = 1'b0;
    logic [7:0]    prescaler = 8'd2;
    logic [7:0]    hold_time = 8'd0;
    phase_strobe_t strobe;
    phase_strobe_t prev_strobe = '0;
    phase_strobe_t rise;
    logic          scl_en;
    logic          sda_en;

    // transaction settings and driver state
    logic          t_rw   = 1'b0;
    logic          t_rs   = 1'b0;
    logic [15:0]   t_acks = '0;
    int            t_n    = 1;
    int            t_p    = 2;
    int            t_h    = 0;
    int            t_id   = 0;
    logic          go        = 1'b0;
    logic          busy      = 1'b0;
    logic          txn_pulse = 1'b0;
    logic          end_pulse = 1'b0;
    logic [3:0]    ack_idx   = 4'd0;
    int            byte_cnt  = 0;
    int            value_errs;
    int            timing_errs;

    i2c_master_ctrl UUT (
        .i2c_core_clock_i (clk),
        .reset_bit_i      (reset_bit),
        .cmd_i            (cmd),
        .fifo_status_i    (fifo),
        .sda_i            (sda),
        .prescaler_i      (prescaler),
        .hold_time_i      (hold_time),
        .strobe_o         (strobe),
        .scl_en_o         (scl_en),
        .sda_en_o         (sda_en)
    );

    i2c_ctrl_checker u_checker (
        .i2c_core_clock_i (clk),
        .reset_bit_i      (reset_bit),
        .strobe_i         (strobe),
        .scl_en_i         (scl_en),
        .sda_en_i         (sda_en),
        .txn_start_i      (txn_pulse),
        .txn_end_i        (end_pulse),
        .rw_i             (t_rw),
        .rs_i             (t_rs),
        .acks_i           (t_acks),
        .nbytes_i         (t_n),
        .presc_i          (t_p),
        .hold_i           (t_h),
        .txn_id_i         (t_id),
        .value_errs_o     (value_errs),
        .timing_errs_o    (timing_errs)
    );

    initial forever #10 clk = ~clk;

    assign rise = strobe & ~prev_strobe;

    // --------------------
    // driver and slave model
    always @(posedge clk) begin
        txn_pulse   <= 1'b0;
        prev_strobe <= strobe;
        if (go && !busy) begin
            cmd       <= {1'b1, t_rw, t_rs};
            fifo      <= '0;
            prescaler <= 8'(t_p);
            hold_time <= 8'(t_h);
            sda       <= t_acks[0];              // first ack bit preloaded
            ack_idx   <= 4'd0;
            byte_cnt  <= 0;
            busy      <= 1'b1;
            txn_pulse <= 1'b1;
        end else if (busy) begin
            if (strobe.start_cnt)
                cmd.enable <= 1'b0;
            if (strobe.repeat_start_cnt)
                cmd.repeat_start <= 1'b0;
            if (prev_strobe.read_ack_cnt && !strobe.read_ack_cnt) begin
                ack_idx <= ack_idx + 4'd1;       // next ack slot response
                sda     <= t_acks[ack_idx + 4'd1];
            end
            if (rise.write_data_cnt || rise.read_data_cnt) begin
                byte_cnt <= byte_cnt + 1;
                if (byte_cnt + 1 >= t_n) begin
                    if (t_rw)
                        fifo.rev_full <= 1'b1;
                    else
                        fifo.trans_empty <= 1'b1;
                end
            end
            if (prev_strobe.stop_cnt && !strobe.stop_cnt)
                busy <= 1'b0;
        end
    end

    task automatic run_txn();
        @(posedge clk);
        go <= 1'b1;
        @(posedge clk);
        go <= 1'b0;
        @(posedge clk);
        while (busy)
            @(posedge clk);
        repeat (4) @(posedge clk);
    endtask

    task automatic pick_txn(input int t);
        t_id = t;
        case (t)
            0: begin t_rw = 0; t_rs = 0; t_acks = 16'h0000; t_n = 2; t_p = 2; t_h = 0; end
            1: begin t_rw = 1; t_rs = 0; t_acks = 16'h0000; t_n = 2; t_p = 3; t_h = 3; end
            2: begin t_rw = 0; t_rs = 0; t_acks = 16'h0001; t_n = 2; t_p = 4; t_h = 1; end
            3: begin t_rw = 0; t_rs = 1; t_acks = 16'h0001; t_n = 1; t_p = 2; t_h = 2; end
            4: begin t_rw = 0; t_rs = 0; t_acks = 16'h0004; t_n = 3; t_p = 5; t_h = 0; end
            default: begin
                t_rw   = ($urandom_range(1, 0) == 1);
                t_rs   = ($urandom_range(1, 0) == 1);
                t_acks = 16'($urandom & $urandom);   // about one nack in four
                t_n    = int'($urandom_range(3, 1));
                t_p    = int'($urandom_range(6, 2));
                t_h    = int'($urandom_range(7, 0));
            end
        endcase
    endtask

    // --------------------
    // main sequence
    initial begin
        void'($urandom(32'heed1199d));
        repeat (3) @(posedge clk);
        reset_bit <= 1'b1;
        for (int t = 0; t < NTXN; t++) begin
            pick_txn(t);
            run_txn();
        end
        @(posedge clk);
        end_pulse <= 1'b1;
        @(posedge clk);
        end_pulse <= 1'b0;
        repeat (2) @(posedge clk);
        $display("errors: value %0d, timing %0d", value_errs, timing_errs);
        if (value_errs + timing_errs == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all transactions finished");
        $display("Test failed");
        $finish;
    end

endmodule

// ==== tb.f ====
hw/i2c_ctrl_pkg.sv
hw/i2c_bit_timer.sv
hw/i2c_seq_decode.sv
hw/i2c_line_ctrl.sv
hw/i2c_master_ctrl.sv
dv/i2c_ctrl_checker.sv
dv/i2c_ctrl_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
    --top-module i2c_ctrl_tb \
    --Mdir obj_dir -o sim \
    -f tb.f

./obj_dir/sim | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
